//--- source/present_pkg.sv
// PRESENT-80 shared definitions
package present_pkg;

    typedef logic [63:0] block_t;
    typedef logic [79:0] key_t;
    typedef logic [4:0]  round_idx_t;

    // index of the final whitening key.
    localparam round_idx_t LAST_ROUND = 5'd31;
    localparam int         ROUND_KEYS = 32;

    // ##################################################################
    // substitution tables
    // ##################################################################

    localparam logic [3:0] SBOX [16] = '{
        4'hc, 4'h5, 4'h6, 4'hb, 4'h9, 4'h0, 4'ha, 4'hd,
        4'h3, 4'he, 4'hf, 4'h8, 4'h4, 4'h7, 4'h1, 4'h2
    };

    localparam logic [3:0] INV_SBOX [16] = '{
        4'h5, 4'he, 4'hf, 4'h8, 4'hc, 4'h1, 4'h2, 4'hd,
        4'hb, 4'h4, 4'h6, 4'h3, 4'h0, 4'h7, 4'h9, 4'ha
    };

    function automatic logic [3:0] sbox_nibble(input logic [3:0] n);
        return SBOX[n];
    endfunction

    function automatic block_t sbox_layer(input block_t s);
        block_t r;
        for (int n = 0; n < 16; n++) begin
            r[4*n +: 4] = SBOX[s[4*n +: 4]];
        end
        return r;
    endfunction

    function automatic block_t inv_sbox_layer(input block_t s);
        block_t r;
        for (int n = 0; n < 16; n++) begin
            r[4*n +: 4] = INV_SBOX[s[4*n +: 4]];
        end
        return r;
    endfunction

    // ##################################################################
    // bit permutation
    // ##################################################################

    // bit i moves to (16 * i) mod 63, bit 63 stays.
    function automatic block_t p_layer(input block_t s);
        block_t r;
        for (int i = 0; i < 63; i++) begin
            r[(i * 16) % 63] = s[i];
        end
        r[63] = s[63];
        return r;
    endfunction

    function automatic block_t inv_p_layer(input block_t s);
        block_t r;
        for (int i = 0; i < 63; i++) begin
            r[i] = s[(i * 16) % 63];
        end
        r[63] = s[63];
        return r;
    endfunction

endpackage : present_pkg

//--- source/cipher_core_if.sv
// Cipher core request and result bundle
interface cipher_core_if import present_pkg::*; ();

    // request from the top.
    logic       start;
    block_t     text;

    // round-key lookup, answered in the same cycle.
    round_idx_t key_index;
    block_t     round_key;

    // completion.
    block_t     result;
    logic       done;

    modport core (
        input  start,
        input  text,
        input  round_key,
        output key_index,
        output result,
        output done
    );

    modport ctrl (
        output start,
        output text,
        output round_key,
        input  key_index,
        input  result,
        input  done
    );

endinterface : cipher_core_if

//--- source/present_key_schedule.sv
// PRESENT-80 key schedule
module present_key_schedule import present_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  key_t       key_i,
    input  round_idx_t rd_index_i,
    output block_t     round_key_o,
    output logic       ready_o
);

    typedef enum logic [2:0] {
        IDLE,
        STORE,
        ROTATE,
        SBOX,
        XOR_COUNT,
        READY
    } ks_state_t;

    ks_state_t  state;
    round_idx_t count;
    key_t       key_q;
    block_t     key_store [ROUND_KEYS];

    // ##################################################################
    // control
    // ##################################################################

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            count <= '0;
        end else begin
            case (state)
                IDLE: begin
                    count <= '0;
                    state <= STORE;
                end
                STORE: begin
                    if (count == LAST_ROUND) begin
                        state <= READY;
                    end else begin
                        state <= ROTATE;
                    end
                end
                ROTATE: begin
                    // counter now holds the round number for the xor.
                    count <= count + 5'd1;
                    state <= SBOX;
                end
                SBOX: begin
                    state <= XOR_COUNT;
                end
                XOR_COUNT: begin
                    state <= STORE;
                end
                READY: begin
                    state <= READY;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // ##################################################################
    // key register and round-key store
    // ##################################################################

    always_ff @(posedge clk) begin
        case (state)
            IDLE: begin
                key_q <= key_i;
            end
            ROTATE: begin
                // rotate left by 61.
                key_q <= {key_q[18:0], key_q[79:19]};
            end
            SBOX: begin
                key_q[79:76] <= sbox_nibble(key_q[79:76]);
            end
            XOR_COUNT: begin
                key_q[19:15] <= key_q[19:15] ^ count;
            end
            default: begin
                key_q <= key_q;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (state == STORE) begin
            key_store[count] <= key_q[79:16];
        end
    end

    assign round_key_o = key_store[rd_index_i];
    assign ready_o     = (state == READY);

    // keys stay valid until the next reset.
    ready_held: assert property (@(posedge clk) ready_o && !rst |=> ready_o)
        else $error("key schedule ready dropped without reset");

endmodule : present_key_schedule

//--- source/present_enc_core.sv
// PRESENT-80 encryption core
module present_enc_core import present_pkg::*; (
    input logic         clk,
    input logic         rst,
    cipher_core_if.core core
);

    logic       running;
    round_idx_t idx;
    block_t     state;
    block_t     round_out;

    // one full round with the current key.
    assign round_out = p_layer(sbox_layer(state ^ core.round_key));

    // ##################################################################
    // round counter
    // ##################################################################

    always_ff @(posedge clk) begin
        if (rst) begin
            running <= 1'b0;
            idx     <= '0;
        end else if (core.start) begin
            running <= 1'b1;
            idx     <= '0;
        end else if (running) begin
            if (idx == LAST_ROUND) begin
                running <= 1'b0;
            end else begin
                idx <= idx + 5'd1;
            end
        end
    end

    // ##################################################################
    // state register
    // ##################################################################

    always_ff @(posedge clk) begin
        if (core.start) begin
            state <= core.text;
        end else if (running && idx != LAST_ROUND) begin
            state <= round_out;
        end
    end

    assign core.key_index = idx;

    // final whitening with key 31.
    assign core.result = state ^ core.round_key;
    assign core.done   = running && (idx == LAST_ROUND);

    // a restart clears the counter, so done cannot repeat.
    enc_done_single: assert property (
        @(posedge clk) disable iff (rst)
        core.done |=> !core.done
    ) else $error("encryption done held for two cycles");

endmodule : present_enc_core

//--- source/present_dec_core.sv
// PRESENT-80 decryption core
module present_dec_core import present_pkg::*; (
    input logic         clk,
    input logic         rst,
    cipher_core_if.core core
);

    logic       running;
    round_idx_t idx;
    block_t     state;
    block_t     round_out;

    // key 31 is plain whitening, the rest are inverse rounds.
    always_comb begin
        if (idx == LAST_ROUND) begin
            round_out = state ^ core.round_key;
        end else begin
            round_out = inv_sbox_layer(inv_p_layer(state)) ^ core.round_key;
        end
    end

    // ##################################################################
    // round counter
    // ##################################################################

    always_ff @(posedge clk) begin
        if (rst) begin
            running <= 1'b0;
            idx     <= '0;
        end else if (core.start) begin
            running <= 1'b1;
            idx     <= LAST_ROUND;
        end else if (running) begin
            if (idx == '0) begin
                running <= 1'b0;
            end else begin
                idx <= idx - 5'd1;
            end
        end
    end

    // ##################################################################
    // state register
    // ##################################################################

    always_ff @(posedge clk) begin
        if (core.start) begin
            state <= core.text;
        end else if (running && idx != '0) begin
            state <= round_out;
        end
    end

    assign core.key_index = idx;

    // round 0 completes combinationally.
    assign core.result = round_out;
    assign core.done   = running && (idx == '0);

    dec_index_down: assert property (
        @(posedge clk) disable iff (rst)
        running && !core.start && idx != '0 |=> core.key_index < $past(core.key_index)
    ) else $error("decryption key index did not decrease");

endmodule : present_dec_core

//--- source/present_top.sv
// PRESENT-80 cipher top level
module present_top import present_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  key_t   key_i,
    input  block_t block_i,
    input  logic   decrypt_i,
    input  logic   start_i,
    output logic   keys_ready_o,
    output block_t block_o_o,
    output logic   done_o
);

    cipher_core_if enc_bus ();
    cipher_core_if dec_bus ();

    logic       start_ok;
    logic       start_enc_q;
    logic       start_dec_q;
    logic       mode_q;
    logic       pending;
    logic       sel_done;
    block_t     text_q;
    block_t     sel_result;
    block_t     round_key;
    round_idx_t rd_index;

    assign start_ok = start_i && keys_ready_o;
    assign pending  = start_enc_q || start_dec_q;

    // ##################################################################
    // request capture
    // ##################################################################

    always_ff @(posedge clk) begin
        if (rst) begin
            start_enc_q <= 1'b0;
            start_dec_q <= 1'b0;
            mode_q      <= 1'b0;
        end else begin
            start_enc_q <= start_ok && !decrypt_i;
            start_dec_q <= start_ok && decrypt_i;
            if (start_ok) begin
                mode_q <= decrypt_i;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start_ok) begin
            text_q <= block_i;
        end
    end

    assign enc_bus.start     = start_enc_q;
    assign enc_bus.text      = text_q;
    assign enc_bus.round_key = round_key;
    assign dec_bus.start     = start_dec_q;
    assign dec_bus.text      = text_q;
    assign dec_bus.round_key = round_key;

    // only the core of the latched mode owns the key store.
    assign rd_index   = mode_q ? dec_bus.key_index : enc_bus.key_index;
    assign sel_done   = mode_q ? dec_bus.done : enc_bus.done;
    assign sel_result = mode_q ? dec_bus.result : enc_bus.result;

    present_key_schedule key_schedule_inst (
        .clk        (clk),
        .rst        (rst),
        .key_i      (key_i),
        .rd_index_i (rd_index),
        .round_key_o(round_key),
        .ready_o    (keys_ready_o)
    );

    present_enc_core enc_core_inst (
        .clk (clk),
        .rst (rst),
        .core(enc_bus)
    );

    present_dec_core dec_core_inst (
        .clk (clk),
        .rst (rst),
        .core(dec_bus)
    );

    // ##################################################################
    // result and done
    // ##################################################################

    // a done from an aborted run is dropped while a restart is pending.
    always_ff @(posedge clk) begin
        if (rst) begin
            done_o    <= 1'b0;
            block_o_o <= '0;
        end else if (start_ok) begin
            done_o <= 1'b0;
        end else if (sel_done && !pending) begin
            done_o    <= 1'b1;
            block_o_o <= sel_result;
        end
    end

    // done rises exactly 33 cycles after the last accepted start.
    done_after_start: assert property (
        @(posedge clk) disable iff (rst)
        $rose(done_o) |-> $past(start_ok, 34)
    ) else $error("done rose without an accepted start");

endmodule : present_top

//--- bench/tb_clock.sv
// Testbench clock source
module tb_clock (
    output logic clk_o
);

    localparam int HALF_PERIOD = 5;

    // period of 10 time units.
    initial begin
        clk_o = 1'b0;
        forever begin
            #HALF_PERIOD clk_o = ~clk_o;
        end
    end

endmodule : tb_clock

//--- bench/present_tb.sv
// PRESENT-80 cipher testbench
module present_tb import present_pkg::*; ();

    localparam int          CYCLE_LIMIT = 4000;
    localparam int          READY_LIMIT = 140;
    localparam logic [31:0] SEED        = 32'h75e8_cd75;
    localparam key_t        KEY_ONES    = '1;
    localparam block_t      BLOCK_ONES  = '1;

    logic   clk;
    logic   rst;
    key_t   key;
    block_t block_in;
    logic   decrypt;
    logic   start;
    logic   keys_ready;
    block_t block_out;
    logic   done;

    int cycle_count = 0;
    int accepted_starts = 0;

    tb_clock clock_inst (
        .clk_o(clk)
    );

    present_top present_top_inst (
        .clk         (clk),
        .rst         (rst),
        .key_i       (key),
        .block_i     (block_in),
        .decrypt_i   (decrypt),
        .start_i     (start),
        .keys_ready_o(keys_ready),
        .block_o_o   (block_out),
        .done_o      (done)
    );

    task automatic stop_with_failure(input string why);
        $display("Errors found");
        $display("%s", why);
        $fatal(1, "run stopped at cycle %0d", cycle_count);
    endtask

    task automatic check_value(input string name, input block_t expected, input block_t actual);
        assert (actual == expected)
        else stop_with_failure($sformatf("ERR %s expected %h actual %h", name, expected, actual));
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        assert (actual == expected)
        else stop_with_failure($sformatf("ERR %s expected %b actual %b", name, expected, actual));
    endtask

    // ##################################################################
    // cycle counter and concurrent checks
    // ##################################################################

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == CYCLE_LIMIT) begin
            stop_with_failure("timeout: the tests did not finish in time");
        end
    end

    always @(posedge clk) begin
        if (rst) begin
            accepted_starts <= 0;
        end else if (start && keys_ready) begin
            accepted_starts <= accepted_starts + 1;
        end
    end

    ready_stays_high: assert property (
        @(posedge clk) disable iff (rst) keys_ready |=> keys_ready
    ) else stop_with_failure("keys_ready_o fell while reset was low");

    done_cleared: assert property (
        @(posedge clk) disable iff (rst) start && keys_ready |=> !done
    ) else stop_with_failure("done_o stayed high after an accepted start");

    no_early_done: assert property (
        @(posedge clk) disable iff (rst) accepted_starts == 0 |-> !done
    ) else stop_with_failure("done_o rose without an accepted start");

    block_held: assert property (
        @(posedge clk) disable iff (rst) !$stable(block_out) |-> $rose(done)
    ) else stop_with_failure("block_o_o changed between completions");

    // ##################################################################
    // stimulus tasks
    // ##################################################################

    // inputs change one time unit after the rising edge.
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) next_cycle();
    endtask

    task automatic apply_reset(input key_t new_key);
        key   = new_key;
        rst   = 1'b1;
        start = 1'b0;
        for (int i = 0; i < 8; i++) begin
            next_cycle();
            check_flag("reset done_o", 1'b0, done);
            check_flag("reset keys_ready_o", 1'b0, keys_ready);
        end
        rst = 1'b0;
        next_cycle();
        check_flag("after reset done_o", 1'b0, done);
        check_flag("after reset keys_ready_o", 1'b0, keys_ready);
    endtask

    task automatic wait_keys_ready();
        int waited;
        waited = 0;
        while (!keys_ready) begin
            if (waited == READY_LIMIT) begin
                stop_with_failure("keys_ready_o did not rise after reset");
            end
            next_cycle();
            waited++;
        end
    endtask

    task automatic start_only(input block_t data, input logic dec);
        block_in = data;
        decrypt  = dec;
        start    = 1'b1;
        next_cycle();
        start = 1'b0;
    endtask

    task automatic run_op(input block_t data, input logic dec, output block_t result);
        start_only(data, dec);
        while (!done) begin
            next_cycle();
        end
        result = block_out;
    endtask

    // result must also hold while no new request comes.
    task automatic expect_op(input string name, input block_t data, input logic dec,
                             input block_t expected);
        block_t result;
        run_op(data, dec, result);
        check_value(name, expected, result);
        idle($urandom_range(8, 1));
        check_flag({name, " done held"}, 1'b1, done);
        check_value({name, " hold"}, result, block_out);
    endtask

    // ##################################################################
    // test sequence
    // ##################################################################

    initial begin
        block_t plain;
        block_t cipher;
        key_t   rand_key;

        rst      = 1'b1;
        key      = '0;
        block_in = '0;
        decrypt  = 1'b0;
        start    = 1'b0;
        void'($urandom(SEED));

        // starts while the schedule runs are dropped.
        apply_reset('0);
        start_only(BLOCK_ONES, 1'b0);
        idle(20);
        start_only('0, 1'b1);
        wait_keys_ready();
        idle(40);
        check_flag("start before ready", 1'b0, done);

        expect_op("enc key 0 text 0", '0, 1'b0, 64'h5579c1387b228445);
        expect_op("enc key 0 text 1s", BLOCK_ONES, 1'b0, 64'ha112ffc72f68417b);
        expect_op("dec key 0 text 0", 64'h5579c1387b228445, 1'b1, '0);
        expect_op("dec key 0 text 1s", 64'ha112ffc72f68417b, 1'b1, BLOCK_ONES);

        // abort in mid run, then right at the old completion.
        start_only({$urandom(), $urandom()}, 1'b0);
        idle(10);
        expect_op("early restart", BLOCK_ONES, 1'b0, 64'ha112ffc72f68417b);
        start_only({$urandom(), $urandom()}, 1'b0);
        idle(32);
        expect_op("late restart to decrypt", 64'h5579c1387b228445, 1'b1, '0);

        apply_reset(KEY_ONES);
        wait_keys_ready();
        expect_op("enc key 1s text 0", '0, 1'b0, 64'he72c46c0f5945049);
        expect_op("enc key 1s text 1s", BLOCK_ONES, 1'b0, 64'h3333dcd3213210d2);
        expect_op("dec key 1s text 0", 64'he72c46c0f5945049, 1'b1, '0);
        expect_op("dec key 1s text 1s", 64'h3333dcd3213210d2, 1'b1, BLOCK_ONES);

        rand_key = {$urandom(), $urandom(), 16'($urandom())};
        apply_reset(rand_key);
        wait_keys_ready();
        for (int n = 0; n < 20; n++) begin
            plain = {$urandom(), $urandom()};
            run_op(plain, 1'b0, cipher);
            expect_op($sformatf("round trip %0d", n), cipher, 1'b1, plain);
        end

        $display("No errors");
        $finish;
    end

endmodule : present_tb

//--- filelist.f
source/present_pkg.sv
source/cipher_core_if.sv
source/present_key_schedule.sv
source/present_enc_core.sv
source/present_dec_core.sv
source/present_top.sv
bench/tb_clock.sv
bench/present_tb.sv

//--- run.sh
#!/bin/sh
# build and run the PRESENT-80 testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --assert --timing -f filelist.f --top-module present_tb -o present_sim &&
./obj_dir/present_sim ||
{ echo "simulation failed"; exit 1; }
